// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= riscv_block_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "tests failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -qx "all tests passed" $(LOG); then echo "Simulation incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim.f ====
verilog/block_map_pkg.sv
verilog/block_bus_pkg.sv
verilog/core_bus_router.sv
verilog/local_mem.sv
verilog/accel_regs.sv
verilog/line_sum_accel.sv
verilog/riscv_block.sv
verification/riscv_block_tb.sv

// ==== verification/riscv_block_tb.sv ====
module riscv_block_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DMEM_SIZE = 4096;
  localparam int PMEM_SIZE = 8192;
  localparam int DMEM_LINES = DMEM_SIZE / block_map_pkg::LINE_BYTES;
  localparam int PMEM_LINES = PMEM_SIZE / block_map_pkg::LINE_BYTES;
  localparam int BC_START = DMEM_SIZE - block_map_pkg::BC_REGION_BYTES;
  localparam int BC_LINE0 = BC_START / block_map_pkg::LINE_BYTES;
  localparam int N_OPS = 40;
  localparam int N_ACCEL = 4;
  localparam int POLL_MAX = 200;
  // Bound per access leaves room for DMA reads stalled by random ready
  localparam int CYCLE_LIMIT = 20 + 3 * (DMEM_LINES + PMEM_LINES) + N_OPS * 6 * 40 +
                               DMEM_LINES * 4 * 3 + N_ACCEL * (POLL_MAX * 3 + N_OPS * 40);

  logic sys_clk = 1'b0;
  logic reset;
  block_bus_pkg::core_req_t core_req;
  block_bus_pkg::core_rsp_t core_rsp;
  block_bus_pkg::dma_wr_t dma_wr;
  block_bus_pkg::dma_rd_t dma_rd;
  block_bus_pkg::bc_msg_t bc_msg_in;
  block_bus_pkg::bc_msg_t bc_msg_out;
  logic dma_wr_ready;
  logic dma_rd_ready;
  logic dma_rd_resp_valid;
  logic [127:0] dma_rd_resp_data;
  logic dma_rd_resp_ready;
  logic bc_msg_in_valid;
  logic bc_msg_out_valid;

  logic [15:0] lfsr = 16'd53;
  int cycles = 0;
  logic [127:0] dmem_m [DMEM_LINES];
  logic [127:0] pmem_m [PMEM_LINES];

  riscv_block #(.DMEM_SIZE(DMEM_SIZE), .PMEM_SIZE(PMEM_SIZE)) uut (
    .sys_clk(sys_clk), .reset(reset), .core_req(core_req), .core_rsp(core_rsp),
    .dma_wr(dma_wr), .dma_wr_ready(dma_wr_ready), .dma_rd(dma_rd),
    .dma_rd_ready(dma_rd_ready), .dma_rd_resp_valid(dma_rd_resp_valid),
    .dma_rd_resp_data(dma_rd_resp_data), .dma_rd_resp_ready(dma_rd_resp_ready),
    .bc_msg_in(bc_msg_in), .bc_msg_in_valid(bc_msg_in_valid),
    .bc_msg_out(bc_msg_out), .bc_msg_out_valid(bc_msg_out_valid)
  );

  always #50 sys_clk = ~sys_clk;

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1);
  endtask

  always @(posedge sys_clk) begin
    cycles <= cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      stop_run("Timeout: the run went past its cycle limit");
    end
  end

  // x^16 + x^15 + x^13 + x^4 + 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3]};
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [127:0] rand_line();
    return {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
  endfunction

  function automatic logic [127:0] merge_line(input logic [127:0] old,
                                              input logic [127:0] data,
                                              input logic [15:0] strb);
    logic [127:0] r;
    r = old;
    for (int b = 0; b < 16; b++) begin
      if (strb[b]) r[b*8 +: 8] = data[b*8 +: 8];
    end
    return r;
  endfunction

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) stop_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_line(input string name, input logic [127:0] got,
                            input logic [127:0] exp);
    if (got !== exp) stop_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_msg(input block_bus_pkg::bc_msg_t got,
                           input block_bus_pkg::bc_msg_t exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL bc_msg_out got %h/%h/%h expected %h/%h/%h", got.addr,
               got.strb, got.data, exp.addr, exp.strb, exp.data));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Bus drivers with model updates

  task automatic core_access(input logic [1:0] region, input logic [22:0] offset,
                             input logic wen, input logic [3:0] strb,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    block_bus_pkg::bc_msg_t exp_msg;
    logic bc_exp;
    logic [127:0] lane;
    lane = {4{wdata}};
    bc_exp = wen && region == block_map_pkg::REGION_DMEM && offset >= BC_START;
    exp_msg.addr = 6'((offset - BC_START) >> 2);
    exp_msg.strb = strb;
    exp_msg.data = wdata;
    @(posedge sys_clk);
    core_req <= {1'b1, wen, strb, region, offset, wdata};
    @(posedge sys_clk);
    core_req <= '0;
    if (wen && region == block_map_pkg::REGION_DMEM) begin
      dmem_m[offset[11:4]] = merge_line(dmem_m[offset[11:4]], lane,
                                        16'(strb) << (offset[3:2] * 4));
    end else if (wen && region == block_map_pkg::REGION_PMEM) begin
      pmem_m[offset[12:4]] = merge_line(pmem_m[offset[12:4]], lane,
                                        16'(strb) << (offset[3:2] * 4));
    end
    @(negedge sys_clk);
    if (core_rsp.valid !== !wen) stop_run("Core read response valid at the wrong cycle");
    rdata = core_rsp.rd_data;
    if (bc_msg_out_valid !== bc_exp) stop_run("Broadcast output strobe at the wrong cycle");
    if (bc_exp) check_msg(bc_msg_out, exp_msg);
  endtask

  task automatic dma_write(input logic sel, input logic [15:0] line,
                           input logic [127:0] data, input logic [15:0] strb);
    @(posedge sys_clk);
    dma_wr <= {1'b1, sel, line, data, strb};
    @(negedge sys_clk);
    while (!dma_wr_ready) @(negedge sys_clk);
    @(posedge sys_clk);
    dma_wr <= '0;
    if (sel) pmem_m[line] = merge_line(pmem_m[line], data, strb);
    else dmem_m[line] = merge_line(dmem_m[line], data, strb);
  endtask

  task automatic dma_read(input logic sel, input logic [15:0] line);
    logic [127:0] exp;
    @(posedge sys_clk);
    dma_rd <= {1'b1, sel, line};
    @(negedge sys_clk);
    while (!dma_rd_ready) @(negedge sys_clk);
    exp = sel ? pmem_m[line] : dmem_m[line];
    @(posedge sys_clk);
    dma_rd <= '0;
    dma_rd_resp_ready <= rand_bits(1);
    @(negedge sys_clk);
    // Response must hold until the ready cycle
    while (1) begin
      if (!dma_rd_resp_valid) stop_run("DMA read response dropped before it was accepted");
      check_line("dma_rd_resp_data", dma_rd_resp_data, exp);
      if (dma_rd_resp_ready) break;
      @(posedge sys_clk);
      dma_rd_resp_ready <= rand_bits(1);
      @(negedge sys_clk);
    end
    @(posedge sys_clk);
    dma_rd_resp_ready <= 1'b0;
  endtask

  task automatic send_broadcasts();
    block_bus_pkg::bc_msg_t m;
    for (int i = 0; i < N_OPS; i++) begin
      m.addr = rand_bits(6);
      m.strb = rand_bits(4);
      m.data = rand_bits(32);
      @(posedge sys_clk);
      bc_msg_in <= m;
      bc_msg_in_valid <= 1'b1;
      @(posedge sys_clk);
      bc_msg_in_valid <= 1'b0;
      dmem_m[BC_LINE0 + m.addr[5:2]] = merge_line(dmem_m[BC_LINE0 + m.addr[5:2]],
          {4{m.data}}, 16'(m.strb) << (m.addr[1:0] * 4));
      if (rand_bits(1)) @(posedge sys_clk);
    end
  endtask

  function automatic logic [22:0] reg_off(input logic [2:0] idx);
    return 23'({idx, 2'b00});
  endfunction

  ////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    logic [31:0] rd;
    logic [31:0] exp_sum;
    logic [22:0] off;
    logic [15:0] s_line;
    logic [15:0] n_lines;
    logic sel;
    int polls;
    reset <= 1'b1;
    core_req <= '0;
    dma_wr <= '0;
    dma_rd <= '0;
    dma_rd_resp_ready <= 1'b0;
    bc_msg_in <= '0;
    bc_msg_in_valid <= 1'b0;
    repeat (8) @(posedge sys_clk);
    reset <= 1'b0;
    @(negedge sys_clk);
    if (core_rsp.valid || dma_rd_resp_valid || bc_msg_out_valid || !dma_wr_ready ||
        !dma_rd_ready) stop_run("Outputs not in their reset state");
    // Accelerator idle and not done after reset
    core_access(block_map_pkg::REGION_EXIO, reg_off(block_map_pkg::REG_STATUS), 1'b0,
                4'h0, 32'h0, rd);
    check_word("REG_STATUS", rd, 32'h0);

    // Fill pattern built from memory select and full line address
    for (int l = 0; l < PMEM_LINES; l++) begin
      if (l < DMEM_LINES) dma_write(1'b0, 16'(l), {4{16'h0d00, 16'(l)}}, 16'hffff);
      dma_write(1'b1, 16'(l), {4{16'h9e00, 16'(l)}}, 16'hffff);
    end

    // DMA writes then core reads
    for (int i = 0; i < N_OPS; i++) begin
      sel = rand_bits(1);
      dma_write(sel, sel ? 16'(rand_bits(9)) : 16'(rand_bits(8)), rand_line(), rand_bits(16));
    end
    for (int i = 0; i < N_OPS; i++) begin
      sel = rand_bits(1);
      off = sel ? 23'({rand_bits(11), 2'b00}) : 23'({rand_bits(10), 2'b00});
      core_access(sel ? block_map_pkg::REGION_PMEM : block_map_pkg::REGION_DMEM, off,
                  1'b0, 4'h0, 32'h0, rd);
      check_word("core_rsp.rd_data", rd,
                 sel ? pmem_m[off[12:4]][off[3:2]*32 +: 32] : dmem_m[off[11:4]][off[3:2]*32 +: 32]);
    end

    // Byte-strobed core writes and register readback
    for (int i = 0; i < N_OPS; i++) begin
      sel = rand_bits(1);
      off = sel ? 23'({rand_bits(11), 2'b00}) : 23'({rand_bits(10), 2'b00});
      core_access(sel ? block_map_pkg::REGION_PMEM : block_map_pkg::REGION_DMEM, off,
                  1'b1, rand_bits(4), rand_bits(32), rd);
      core_access(sel ? block_map_pkg::REGION_PMEM : block_map_pkg::REGION_DMEM, off,
                  1'b0, 4'h0, 32'h0, rd);
      check_word("core_rsp.rd_data", rd,
                 sel ? pmem_m[off[12:4]][off[3:2]*32 +: 32] : dmem_m[off[11:4]][off[3:2]*32 +: 32]);
    end
    s_line = rand_bits(16);
    n_lines = rand_bits(16);
    core_access(block_map_pkg::REGION_EXIO, reg_off(block_map_pkg::REG_START_LINE), 1'b1,
                4'hf, {16'hffff, s_line}, rd);
    core_access(block_map_pkg::REGION_EXIO, reg_off(block_map_pkg::REG_LINE_COUNT), 1'b1,
                4'hf, {16'hffff, n_lines}, rd);
    core_access(block_map_pkg::REGION_EXIO, reg_off(block_map_pkg::REG_START_LINE), 1'b0,
                4'h0, 32'h0, rd);
    check_word("start_line register", rd, {16'h0, s_line});
    core_access(block_map_pkg::REGION_EXIO, reg_off(block_map_pkg::REG_LINE_COUNT), 1'b0,
                4'h0, 32'h0, rd);
    check_word("line_count register", rd, {16'h0, n_lines});

    // Broadcast out with half of the writes aimed at the region
    for (int i = 0; i < N_OPS; i++) begin
      off = rand_bits(1) ? 23'(BC_START + {rand_bits(6), 2'b00}) : 23'({rand_bits(10), 2'b00});
      core_access(block_map_pkg::REGION_DMEM, off, 1'b1, rand_bits(4), rand_bits(32), rd);
    end

    // Broadcast input racing DMA writes into dmem
    fork
      send_broadcasts();
      for (int i = 0; i < N_OPS; i++) begin
        dma_write(1'b0, 16'(rand_bits(7)), rand_line(), rand_bits(16));
      end
    join
    for (int w = 0; w < DMEM_LINES * 4; w++) begin
      core_access(block_map_pkg::REGION_DMEM, 23'(w * 4), 1'b0, 4'h0, 32'h0, rd);
      check_word("core_rsp.rd_data", rd, dmem_m[w / 4][(w % 4)*32 +: 32]);
    end

    // DMA reads under random response ready
    for (int i = 0; i < N_OPS; i++) begin
      sel = rand_bits(1);
      dma_read(sel, sel ? 16'(rand_bits(9)) : 16'(rand_bits(8)));
    end

    // Accelerator sums beside pmem DMA reads
    for (int r = 0; r < N_ACCEL; r++) begin
      s_line = 16'(rand_bits(9) % (PMEM_LINES - 8));
      n_lines = 16'(rand_bits(3) + 1);
      exp_sum = '0;
      for (int l = 0; l < n_lines; l++) begin
        for (int w = 0; w < 4; w++) exp_sum = exp_sum + pmem_m[s_line + l][w*32 +: 32];
      end
      core_access(block_map_pkg::REGION_EXIO, reg_off(block_map_pkg::REG_START_LINE), 1'b1,
                  4'hf, {16'h0, s_line}, rd);
      core_access(block_map_pkg::REGION_EXIO, reg_off(block_map_pkg::REG_LINE_COUNT), 1'b1,
                  4'hf, {16'h0, n_lines}, rd);
      core_access(block_map_pkg::REGION_EXIO, reg_off(block_map_pkg::REG_CTRL), 1'b1,
                  4'hf, 32'h1, rd);
      fork
        begin
          polls = 0;
          rd = '0;
          while (!rd[1] && polls < POLL_MAX) begin
            core_access(block_map_pkg::REGION_EXIO, reg_off(block_map_pkg::REG_STATUS),
                        1'b0, 4'h0, 32'h0, rd);
            polls++;
          end
          if (!rd[1]) stop_run("Accelerator never reported done");
          // Done shows with busy already low
          check_word("REG_STATUS", rd, 32'h2);
        end
        for (int i = 0; i < N_OPS / 4; i++) dma_read(1'b1, 16'(rand_bits(9)));
      join
      core_access(block_map_pkg::REGION_EXIO, reg_off(block_map_pkg::REG_RESULT), 1'b0,
                  4'h0, 32'h0, rd);
      check_word("REG_RESULT", rd, exp_sum);
    end

    $display("all tests passed");
    $finish;
  end

endmodule

// ==== verilog/accel_regs.sv ====
module accel_regs (
  input  logic                     sys_clk,
  input  logic                     reset,
  input  block_bus_pkg::core_req_t exio_req,
  output block_bus_pkg::core_rsp_t exio_rsp,
  output logic [15:0]              start_line,
  output logic [15:0]              line_count,
  output logic                     start,
  input  logic                     busy,
  input  logic                     done,
  input  logic [31:0]              sum
);

  localparam int IW = block_map_pkg::REG_IDX_WIDTH;

  logic [IW-1:0] idx;
  logic          reg_wr;
  logic [31:0]   rd_word;

  function automatic logic [15:0] merge_half(logic [15:0] old, logic [1:0] strb,
                                             logic [15:0] data);
    logic [15:0] r;
    r = old;
    if (strb[0]) r[7:0] = data[7:0];
    if (strb[1]) r[15:8] = data[15:8];
    return r;
  endfunction

  assign idx    = exio_req.addr[IW+1:2];
  assign reg_wr = exio_req.en && exio_req.wen;

  // Same-cycle pulse, so status read right after already shows busy
  assign start = reg_wr && (idx == block_map_pkg::REG_CTRL) && exio_req.strb[0] &&
                 exio_req.wr_data[0];

  always_comb begin
    case (idx)
      block_map_pkg::REG_START_LINE: rd_word = {16'h0, start_line};
      block_map_pkg::REG_LINE_COUNT: rd_word = {16'h0, line_count};
      block_map_pkg::REG_STATUS:     rd_word = {30'h0, done, busy};
      block_map_pkg::REG_RESULT:     rd_word = sum;
      default:                       rd_word = 32'h0;
    endcase
  end

  always_ff @(posedge sys_clk) begin
    exio_rsp.rd_data <= rd_word;
    if (reset) begin
      start_line     <= 16'h0;
      line_count     <= 16'h0;
      exio_rsp.valid <= 1'b0;
    end else begin
      if (reg_wr && idx == block_map_pkg::REG_START_LINE) begin
        start_line <= merge_half(start_line, exio_req.strb[1:0], exio_req.wr_data[15:0]);
      end
      if (reg_wr && idx == block_map_pkg::REG_LINE_COUNT) begin
        line_count <= merge_half(line_count, exio_req.strb[1:0], exio_req.wr_data[15:0]);
      end
      exio_rsp.valid <= exio_req.en && !exio_req.wen;
    end
  end

endmodule

// ==== verilog/block_bus_pkg.sv ====
package block_bus_pkg;

  // One core data access, one per cycle
  typedef struct packed {
    logic                                       en;
    logic                                       wen;
    logic [3:0]                                 strb;
    logic [block_map_pkg::CORE_ADDR_WIDTH-1:0]  addr;
    logic [31:0]                                wr_data;
  } core_req_t;

  // Read return
  typedef struct packed {
    logic        valid;
    logic [31:0] rd_data;
  } core_rsp_t;

  // DMA line write, line address in units of LINE_BYTES
  typedef struct packed {
    logic                                       en;
    logic                                       sel_pmem;
    logic [block_map_pkg::LINE_ADDR_WIDTH-1:0]  addr;
    logic [block_map_pkg::LINE_WIDTH-1:0]       data;
    logic [block_map_pkg::LINE_BYTES-1:0]       strb;
  } dma_wr_t;

  typedef struct packed {
    logic                                       en;
    logic                                       sel_pmem;
    logic [block_map_pkg::LINE_ADDR_WIDTH-1:0]  addr;
  } dma_rd_t;

  // Broadcast word, addr is the word offset inside the region
  typedef struct packed {
    logic [block_map_pkg::BC_ADDR_WIDTH-1:0]    addr;
    logic [3:0]                                 strb;
    logic [31:0]                                data;
  } bc_msg_t;

  typedef struct packed {
    logic                                       en;
    logic [block_map_pkg::LINE_ADDR_WIDTH-1:0]  addr;
  } line_rd_t;

endpackage

// ==== verilog/block_map_pkg.sv ====
package block_map_pkg;

  // Memory line geometry
  localparam int LINE_BYTES = 16;
  localparam int LINE_WIDTH = LINE_BYTES * 8;
  localparam int LINE_ADDR_WIDTH = 16;

  // Core address, region code sits in the two top bits
  localparam int CORE_ADDR_WIDTH = 25;
  localparam int REGION_LSB = 23;

  localparam logic [1:0] REGION_DMEM = 2'b00;
  localparam logic [1:0] REGION_PMEM = 2'b01;
  localparam logic [1:0] REGION_EXIO = 2'b10;

  // Broadcast region at the top of dmem, addressed in 32-bit words
  localparam int BC_REGION_BYTES = 256;
  localparam int BC_ADDR_WIDTH = $clog2(BC_REGION_BYTES) - 2;

  // Accelerator register word indexes
  localparam int REG_IDX_WIDTH = 3;

  localparam logic [REG_IDX_WIDTH-1:0] REG_START_LINE = 3'd0;
  localparam logic [REG_IDX_WIDTH-1:0] REG_LINE_COUNT = 3'd1;
  localparam logic [REG_IDX_WIDTH-1:0] REG_CTRL       = 3'd2;
  localparam logic [REG_IDX_WIDTH-1:0] REG_STATUS     = 3'd3;
  localparam logic [REG_IDX_WIDTH-1:0] REG_RESULT     = 3'd4;

endpackage

// ==== verilog/core_bus_router.sv ====
module core_bus_router #(
  parameter int DMEM_SIZE = 4096
) (
  input  logic                     sys_clk,
  input  logic                     reset,
  input  block_bus_pkg::core_req_t core_req,
  output block_bus_pkg::core_req_t dmem_req,
  output block_bus_pkg::core_req_t pmem_req,
  output block_bus_pkg::core_req_t exio_req,
  input  block_bus_pkg::core_rsp_t dmem_rsp,
  input  block_bus_pkg::core_rsp_t pmem_rsp,
  input  block_bus_pkg::core_rsp_t exio_rsp,
  output block_bus_pkg::core_rsp_t core_rsp,
  output block_bus_pkg::bc_msg_t   bc_msg_out,
  output logic                     bc_msg_out_valid
);

  localparam int AW = block_map_pkg::CORE_ADDR_WIDTH;
  localparam int RL = block_map_pkg::REGION_LSB;
  localparam int BW = block_map_pkg::BC_ADDR_WIDTH;
  localparam logic [AW-1:0] BC_START = AW'(DMEM_SIZE - block_map_pkg::BC_REGION_BYTES);

  logic bc_hit;

  // Enable only the selected region, address reduced to the region offset
  function automatic block_bus_pkg::core_req_t route(block_bus_pkg::core_req_t req,
                                                     logic [1:0] code);
    block_bus_pkg::core_req_t r;
    r = req;
    r.en = req.en && (req.addr[RL +: 2] == code);
    r.addr = {2'b00, req.addr[RL-1:0]};
    return r;
  endfunction

  assign dmem_req = route(core_req, block_map_pkg::REGION_DMEM);
  assign pmem_req = route(core_req, block_map_pkg::REGION_PMEM);
  assign exio_req = route(core_req, block_map_pkg::REGION_EXIO);

  // Writes to the dmem top region go out as broadcast messages
  assign bc_hit = dmem_req.en && dmem_req.wen && (dmem_req.addr >= BC_START);

  always_ff @(posedge sys_clk) begin
    if (bc_hit) begin
      bc_msg_out.addr <= dmem_req.addr[BW+1:2];
      bc_msg_out.strb <= dmem_req.strb;
      bc_msg_out.data <= dmem_req.wr_data;
    end
    if (reset) begin
      bc_msg_out_valid <= 1'b0;
    end else begin
      bc_msg_out_valid <= bc_hit;
    end
  end

  // At most one return is valid per cycle
  always_comb begin
    core_rsp.valid = dmem_rsp.valid | pmem_rsp.valid | exio_rsp.valid;
    if (exio_rsp.valid) begin
      core_rsp.rd_data = exio_rsp.rd_data;
    end else if (pmem_rsp.valid) begin
      core_rsp.rd_data = pmem_rsp.rd_data;
    end else begin
      core_rsp.rd_data = dmem_rsp.rd_data;
    end
  end

endmodule

// ==== verilog/line_sum_accel.sv ====
module line_sum_accel (
  input  logic                                  sys_clk,
  input  logic                                  reset,
  input  logic                                  start,
  input  logic [15:0]                           start_line,
  input  logic [15:0]                           line_count,
  output logic                                  busy,
  output logic                                  done,
  output logic [31:0]                           sum,
  output block_bus_pkg::line_rd_t               line_rd,
  input  logic                                  line_rd_grant,
  input  logic                                  line_rd_valid,
  input  logic [block_map_pkg::LINE_WIDTH-1:0]  line_rd_data
);

  localparam int WORDS = block_map_pkg::LINE_WIDTH / 32;

  logic [15:0] base_line;
  logic [15:0] total_lines;
  logic [15:0] issue_cnt;
  logic [15:0] ret_cnt;
  logic [31:0] line_total;

  // Word sum of the returned line
  always_comb begin
    line_total = '0;
    for (int w = 0; w < WORDS; w++) begin
      line_total = line_total + line_rd_data[w*32 +: 32];
    end
  end

  // Issue runs ahead of return, reads stay in flight
  assign line_rd.en   = busy && (issue_cnt != total_lines);
  assign line_rd.addr = base_line + issue_cnt;

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      busy        <= 1'b0;
      done        <= 1'b0;
      sum         <= 32'h0;
      base_line   <= 16'h0;
      total_lines <= 16'h0;
      issue_cnt   <= 16'h0;
      ret_cnt     <= 16'h0;
    end else if (start) begin
      base_line   <= start_line;
      total_lines <= line_count;
      issue_cnt   <= 16'h0;
      ret_cnt     <= 16'h0;
      sum         <= 32'h0;
      busy        <= (line_count != 16'h0);
      done        <= (line_count == 16'h0);
    end else begin
      if (line_rd_grant) begin
        issue_cnt <= issue_cnt + 16'd1;
      end
      if (line_rd_valid && busy) begin
        sum     <= sum + line_total;
        ret_cnt <= ret_cnt + 16'd1;
        if (ret_cnt + 16'd1 == total_lines) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== verilog/local_mem.sv ====
module local_mem #(
  parameter int DMEM_SIZE = 4096,
  parameter int PMEM_SIZE = 8192
) (
  input  logic                                  sys_clk,
  input  logic                                  reset,
  input  block_bus_pkg::core_req_t              dmem_req,
  input  block_bus_pkg::core_req_t              pmem_req,
  output block_bus_pkg::core_rsp_t              dmem_rsp,
  output block_bus_pkg::core_rsp_t              pmem_rsp,
  input  block_bus_pkg::dma_wr_t                dma_wr,
  output logic                                  dma_wr_ready,
  input  block_bus_pkg::dma_rd_t                dma_rd,
  output logic                                  dma_rd_ready,
  output logic                                  dma_rd_resp_valid,
  output logic [block_map_pkg::LINE_WIDTH-1:0]  dma_rd_resp_data,
  input  logic                                  dma_rd_resp_ready,
  input  block_bus_pkg::bc_msg_t                bc_msg_in,
  input  logic                                  bc_msg_in_valid,
  input  block_bus_pkg::line_rd_t               line_rd,
  output logic                                  line_rd_grant,
  output logic                                  line_rd_valid,
  output logic [block_map_pkg::LINE_WIDTH-1:0]  line_rd_data
);

  localparam int LB = block_map_pkg::LINE_BYTES;
  localparam int LW = block_map_pkg::LINE_WIDTH;
  localparam int DMEM_LINES = DMEM_SIZE / LB;
  localparam int PMEM_LINES = PMEM_SIZE / LB;
  localparam int DAW = $clog2(DMEM_LINES);
  localparam int PAW = $clog2(PMEM_LINES);
  localparam int BC_BASE_LINE = (DMEM_SIZE - block_map_pkg::BC_REGION_BYTES) / LB;
  localparam int BW = block_map_pkg::BC_ADDR_WIDTH;

  logic [LW-1:0] dmem [DMEM_LINES];
  logic [LW-1:0] pmem [PMEM_LINES];

  logic          dma_wr_fire;
  logic          dma_rd_fire;
  logic          dma_rd_port_busy;
  logic          dl_wen;
  logic [DAW-1:0] dl_addr;
  logic [LW-1:0] dl_data;
  logic [LB-1:0] dl_strb;
  logic [LB-1:0] bc_strb;
  logic          pl_wen;
  logic [LB-1:0] dc_strb;
  logic [LB-1:0] pc_strb;

  // Place a 32-bit core write into its lane of a line
  function automatic logic [LB-1:0] core_strb(block_bus_pkg::core_req_t req);
    logic [LB-1:0] s;
    s = '0;
    if (req.en && req.wen) begin
      s[req.addr[3:2]*4 +: 4] = req.strb;
    end
    return s;
  endfunction

  ////////////////////////////////////////////////////////////
  // Line port arbitration

  // Broadcast input is never stalled, so a dmem DMA write waits
  assign dma_wr_ready = !(bc_msg_in_valid && !dma_wr.sel_pmem);
  assign dma_wr_fire  = dma_wr.en && dma_wr_ready;

  assign dma_rd_port_busy = dma_rd.sel_pmem ? (dma_wr_fire && dma_wr.sel_pmem) :
                            (bc_msg_in_valid || (dma_wr_fire && !dma_wr.sel_pmem));
  assign dma_rd_ready = !dma_rd_resp_valid && !dma_rd_port_busy;
  assign dma_rd_fire  = dma_rd.en && dma_rd_ready;

  // Accelerator gets pmem only in cycles no DMA command uses it
  assign line_rd_grant = line_rd.en && !(dma_wr_fire && dma_wr.sel_pmem) &&
                         !(dma_rd_fire && dma_rd.sel_pmem);

  assign pl_wen = dma_wr_fire && dma_wr.sel_pmem;

  always_comb begin
    bc_strb = '0;
    bc_strb[bc_msg_in.addr[1:0]*4 +: 4] = bc_msg_in.strb;
    dl_wen  = dma_wr_fire && !dma_wr.sel_pmem;
    dl_addr = dma_wr.addr[DAW-1:0];
    dl_data = dma_wr.data;
    dl_strb = dma_wr.strb;
    if (bc_msg_in_valid) begin
      dl_wen  = 1'b1;
      dl_addr = DAW'(BC_BASE_LINE) + DAW'(bc_msg_in.addr[BW-1:2]);
      dl_data = {4{bc_msg_in.data}};
      dl_strb = bc_strb;
    end
  end

  ////////////////////////////////////////////////////////////
  // Storage with the core write landing after the line write on a shared byte

  assign dc_strb = core_strb(dmem_req);
  assign pc_strb = core_strb(pmem_req);

  always_ff @(posedge sys_clk) begin
    for (int b = 0; b < LB; b++) begin
      if (dl_wen && dl_strb[b]) begin
        dmem[dl_addr][b*8 +: 8] <= dl_data[b*8 +: 8];
      end
      if (dc_strb[b]) begin
        dmem[dmem_req.addr[DAW+3:4]][b*8 +: 8] <= dmem_req.wr_data[(b%4)*8 +: 8];
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    for (int b = 0; b < LB; b++) begin
      if (pl_wen && dma_wr.strb[b]) begin
        pmem[dma_wr.addr[PAW-1:0]][b*8 +: 8] <= dma_wr.data[b*8 +: 8];
      end
      if (pc_strb[b]) begin
        pmem[pmem_req.addr[PAW+3:4]][b*8 +: 8] <= pmem_req.wr_data[(b%4)*8 +: 8];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read returns

  always_ff @(posedge sys_clk) begin
    dmem_rsp.rd_data <= dmem[dmem_req.addr[DAW+3:4]][dmem_req.addr[3:2]*32 +: 32];
    pmem_rsp.rd_data <= pmem[pmem_req.addr[PAW+3:4]][pmem_req.addr[3:2]*32 +: 32];
    line_rd_data <= pmem[line_rd.addr[PAW-1:0]];
    if (dma_rd_fire) begin
      dma_rd_resp_data <= dma_rd.sel_pmem ? pmem[dma_rd.addr[PAW-1:0]] :
                                            dmem[dma_rd.addr[DAW-1:0]];
    end
    if (reset) begin
      dmem_rsp.valid    <= 1'b0;
      pmem_rsp.valid    <= 1'b0;
      line_rd_valid     <= 1'b0;
      dma_rd_resp_valid <= 1'b0;
    end else begin
      dmem_rsp.valid <= dmem_req.en && !dmem_req.wen;
      pmem_rsp.valid <= pmem_req.en && !pmem_req.wen;
      line_rd_valid  <= line_rd_grant;
      // Response held until the sink takes it
      if (dma_rd_fire) begin
        dma_rd_resp_valid <= 1'b1;
      end else if (dma_rd_resp_ready) begin
        dma_rd_resp_valid <= 1'b0;
      end
    end
  end

endmodule

// ==== verilog/riscv_block.sv ====
module riscv_block #(
  parameter int DMEM_SIZE = 4096,
  parameter int PMEM_SIZE = 8192
) (
  input  logic                                  sys_clk,
  input  logic                                  reset,
  input  block_bus_pkg::core_req_t              core_req,
  output block_bus_pkg::core_rsp_t              core_rsp,
  input  block_bus_pkg::dma_wr_t                dma_wr,
  output logic                                  dma_wr_ready,
  input  block_bus_pkg::dma_rd_t                dma_rd,
  output logic                                  dma_rd_ready,
  output logic                                  dma_rd_resp_valid,
  output logic [block_map_pkg::LINE_WIDTH-1:0]  dma_rd_resp_data,
  input  logic                                  dma_rd_resp_ready,
  input  block_bus_pkg::bc_msg_t                bc_msg_in,
  input  logic                                  bc_msg_in_valid,
  output block_bus_pkg::bc_msg_t                bc_msg_out,
  output logic                                  bc_msg_out_valid
);

  block_bus_pkg::core_req_t dmem_req;
  block_bus_pkg::core_req_t pmem_req;
  block_bus_pkg::core_req_t exio_req;
  block_bus_pkg::core_rsp_t dmem_rsp;
  block_bus_pkg::core_rsp_t pmem_rsp;
  block_bus_pkg::core_rsp_t exio_rsp;
  block_bus_pkg::line_rd_t  line_rd;

  logic                                 line_rd_grant;
  logic                                 line_rd_valid;
  logic [block_map_pkg::LINE_WIDTH-1:0] line_rd_data;
  logic [15:0]                          start_line;
  logic [15:0]                          line_count;
  logic                                 accel_start;
  logic                                 accel_busy;
  logic                                 accel_done;
  logic [31:0]                          accel_sum;

  ////////////////////////////////////////////////////////////
  // Core side

  core_bus_router #(
    .DMEM_SIZE(DMEM_SIZE)
  ) router (
    .sys_clk(sys_clk),
    .reset(reset),
    .core_req(core_req),
    .dmem_req(dmem_req),
    .pmem_req(pmem_req),
    .exio_req(exio_req),
    .dmem_rsp(dmem_rsp),
    .pmem_rsp(pmem_rsp),
    .exio_rsp(exio_rsp),
    .core_rsp(core_rsp),
    .bc_msg_out(bc_msg_out),
    .bc_msg_out_valid(bc_msg_out_valid)
  );

  ////////////////////////////////////////////////////////////
  // Memories

  local_mem #(
    .DMEM_SIZE(DMEM_SIZE),
    .PMEM_SIZE(PMEM_SIZE)
  ) memories (
    .sys_clk(sys_clk),
    .reset(reset),
    .dmem_req(dmem_req),
    .pmem_req(pmem_req),
    .dmem_rsp(dmem_rsp),
    .pmem_rsp(pmem_rsp),
    .dma_wr(dma_wr),
    .dma_wr_ready(dma_wr_ready),
    .dma_rd(dma_rd),
    .dma_rd_ready(dma_rd_ready),
    .dma_rd_resp_valid(dma_rd_resp_valid),
    .dma_rd_resp_data(dma_rd_resp_data),
    .dma_rd_resp_ready(dma_rd_resp_ready),
    .bc_msg_in(bc_msg_in),
    .bc_msg_in_valid(bc_msg_in_valid),
    .line_rd(line_rd),
    .line_rd_grant(line_rd_grant),
    .line_rd_valid(line_rd_valid),
    .line_rd_data(line_rd_data)
  );

  ////////////////////////////////////////////////////////////
  // Accelerator

  accel_regs regs (
    .sys_clk(sys_clk),
    .reset(reset),
    .exio_req(exio_req),
    .exio_rsp(exio_rsp),
    .start_line(start_line),
    .line_count(line_count),
    .start(accel_start),
    .busy(accel_busy),
    .done(accel_done),
    .sum(accel_sum)
  );

  line_sum_accel accel (
    .sys_clk(sys_clk),
    .reset(reset),
    .start(accel_start),
    .start_line(start_line),
    .line_count(line_count),
    .busy(accel_busy),
    .done(accel_done),
    .sum(accel_sum),
    .line_rd(line_rd),
    .line_rd_grant(line_rd_grant),
    .line_rd_valid(line_rd_valid),
    .line_rd_data(line_rd_data)
  );

endmodule
